//--- bench/dmmu_chk.sv
module dmmu_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             flush,
    input logic             miss_valid,
    input logic             miss_ready,
    input logic             paddr_valid,
    input logic             paddr_ready,
    input dmmu_pkg::paddr_t paddr,
    input logic             paddr_error
);

    // **************************************************
    // reset state
    // **************************************************
    reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !paddr_valid && !miss_valid
    ) else $error("paddr_valid or miss_valid is high while in reset");

    // **************************************************
    // handshakes
    // **************************************************

    // output slot holds while the cache stalls
    paddr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        paddr_valid && !paddr_ready && !flush
            |=> paddr_valid && $stable(paddr) && $stable(paddr_error)
    ) else $error("paddr or paddr_error changed while the cache stalled");

    // walk request stays up until taken
    miss_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        miss_valid && !miss_ready && !flush |=> miss_valid
    ) else $error("miss_valid dropped before miss_ready");

endmodule

//--- bench/dmmu_tb.sv
module dmmu_tb;

    localparam int MAX_CYCLES = 2000;
    localparam int WAIT_LIMIT = 100;
    localparam logic [3:0] SATP_SV39 = 4'h8;

    // permissions as {g, u, x, w, r}
    localparam logic [4:0] P_R = 5'b00001;
    localparam logic [4:0] P_W = 5'b00010;
    localparam logic [4:0] P_X = 5'b00100;
    localparam logic [4:0] P_U = 5'b01000;
    localparam logic [4:0] P_G = 5'b10000;

    // low six bits differ so no two pages share a TLB slot
    localparam dmmu_pkg::vpn_t VPN_A = 27'h0012345;
    localparam dmmu_pkg::vpn_t VPN_B = 27'h00A4C41;
    localparam dmmu_pkg::vpn_t VPN_C = 27'h0031382;
    localparam dmmu_pkg::vpn_t VPN_D = 27'h0055103;
    localparam dmmu_pkg::vpn_t VPN_E = 27'h0066144;
    localparam dmmu_pkg::vpn_t VPN_F = 27'h0077186;
    localparam dmmu_pkg::vpn_t VPN_G = 27'h00881C7;
    localparam dmmu_pkg::vpn_t VPN_H = 27'h0099208;
    localparam dmmu_pkg::vpn_t VPN_J = 27'h00AA249;
    localparam dmmu_pkg::vpn_t VPN_K = 27'h00BB28A;

    logic             clk;
    logic             rst_n;
    dmmu_pkg::priv_t  current_priv;
    logic             mprv;
    dmmu_pkg::priv_t  mpp;
    logic             mxr;
    logic             sum;
    logic [3:0]       satp_mode;
    dmmu_pkg::asid_t  satp_asid;
    logic             flush;
    logic             sflush_vma_valid;
    logic             miss_valid;
    logic             miss_ready;
    dmmu_pkg::vaddr_t miss_vaddr;
    logic             pte_valid;
    dmmu_pkg::pte_t   pte;
    logic             pte_error;
    logic             mmu_fifo_valid;
    logic             mmu_fifo_ready;
    dmmu_pkg::vaddr_t vaddr;
    logic             store;
    logic             paddr_valid;
    logic             paddr_ready;
    dmmu_pkg::paddr_t paddr;
    logic             paddr_error;

    int seed = 578;
    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    int delay;
    string test_name;
    dmmu_pkg::vpn_t resp_vpn;
    dmmu_pkg::pte_t pte_table [dmmu_pkg::vpn_t];
    logic           err_table [dmmu_pkg::vpn_t];

    dmmu_top #(
        .TLB_ENTRIES (64)
    ) dut0 (.*);

    bind dmmu_top dmmu_chk chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .miss_valid  (miss_valid),
        .miss_ready  (miss_ready),
        .paddr_valid (paddr_valid),
        .paddr_ready (paddr_ready),
        .paddr       (paddr),
        .paddr_error (paddr_error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // **************************************************
    // helpers
    // **************************************************
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    function automatic dmmu_pkg::ppn_t ppn_for(input dmmu_pkg::vpn_t vpn);
        return {17'h0A5A5, vpn};
    endfunction

    // page offset grows by 9 bits per level
    function automatic dmmu_pkg::paddr_t expected_paddr(input dmmu_pkg::ppn_t ppn,
                                                        input int level,
                                                        input dmmu_pkg::vaddr_t va);
        logic [63:0] mask;
        mask = (64'd1 << (12 + 9 * level)) - 64'd1;
        return ({8'h00, ppn, 12'h000} & ~mask) | (va & mask);
    endfunction

    function automatic dmmu_pkg::vaddr_t page_addr(input dmmu_pkg::vpn_t vpn);
        return {25'h0, vpn, 12'($random(seed)) & 12'hFF8};
    endfunction

    task automatic add_entry(input dmmu_pkg::vpn_t vpn, input dmmu_pkg::asid_t asid,
                             input dmmu_pkg::level_t level, input logic [4:0] perm,
                             input logic err);
        dmmu_pkg::pte_t e;
        e = '0;
        e[dmmu_pkg::PTE_LEVEL_MSB:dmmu_pkg::PTE_LEVEL_LSB] = level;
        e[dmmu_pkg::PTE_VPN_MSB:dmmu_pkg::PTE_VPN_LSB]     = vpn;
        e[dmmu_pkg::PTE_R +: 5]                            = perm;
        e[dmmu_pkg::PTE_PPN_MSB:dmmu_pkg::PTE_PPN_LSB]     = ppn_for(vpn);
        e[dmmu_pkg::PTE_ASID_MSB:dmmu_pkg::PTE_ASID_LSB]   = asid;
        pte_table[vpn] = e;
        err_table[vpn] = err;
    endtask

    // called and returns 1 unit after a rising edge
    task automatic translate(input dmmu_pkg::vaddr_t addr, input logic st,
                             input dmmu_pkg::paddr_t exp_pa, input logic exp_err,
                             input logic exp_miss, input logic check_pa);
        int waited;
        logic saw_miss;
        logic taken;
        waited = 0;
        saw_miss = 1'b0;
        taken = 1'b0;
        mmu_fifo_valid = 1'b1;
        vaddr = addr;
        store = st;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (miss_valid) begin
                saw_miss = 1'b1;
                assert (miss_vaddr == addr) else report_mismatch("miss_vaddr", miss_vaddr, addr);
            end
            taken = mmu_fifo_ready;
            waited++;
            @(posedge clk);
            #1;
        end
        mmu_fifo_valid = 1'b0;
        if (!taken) begin
            $display("request to %h was never accepted", addr);
            errors++;
        end else begin
            @(negedge clk);
            assert (paddr_valid) else report_mismatch("paddr_valid", 64'(paddr_valid), 64'd1);
            if (check_pa) begin
                assert (paddr == exp_pa) else report_mismatch("paddr", paddr, exp_pa);
            end
            assert (paddr_error == exp_err)
                else report_mismatch("paddr_error", 64'(paddr_error), 64'(exp_err));
            assert (saw_miss == exp_miss)
                else report_mismatch("miss_valid", 64'(saw_miss), 64'(exp_miss));
            @(posedge clk);
            #1;
        end
    endtask

    task automatic access_page(input dmmu_pkg::vpn_t vpn, input int level, input logic st,
                               input logic exp_err, input logic exp_miss);
        dmmu_pkg::vaddr_t addr;
        addr = page_addr(vpn);
        translate(addr, st, expected_paddr(ppn_for(vpn), level, addr), exp_err, exp_miss, 1'b1);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, test_name);
        end
    endtask

    // **************************************************
    // second-level TLB model
    // **************************************************
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (miss_valid) begin
                resp_vpn = miss_vaddr[dmmu_pkg::VA_BITS-1:dmmu_pkg::PAGE_OFFSET_BITS];
                // request waits one cycle before it is taken
                @(posedge clk);
                #1;
                miss_ready = 1'b1;
                @(posedge clk);
                #1;
                miss_ready = 1'b0;
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                pte_valid = 1'b1;
                pte = pte_table.exists(resp_vpn) ? pte_table[resp_vpn] : '0;
                pte_error = err_table.exists(resp_vpn) ? err_table[resp_vpn] : 1'b1;
                @(posedge clk);
                #1;
                pte_valid = 1'b0;
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with tests still running", cycles);
        $display("TB FAILED");
        $finish;
    end

    // **************************************************
    // tests
    // **************************************************
    initial begin
        dmmu_pkg::vaddr_t va_a;
        dmmu_pkg::vaddr_t va_k;
        dmmu_pkg::paddr_t held_pa;
        int waited;
        rst_n = 1'b0;
        current_priv = dmmu_pkg::PRV_S;
        mprv = 1'b0;
        mpp = dmmu_pkg::PRV_U;
        mxr = 1'b0;
        sum = 1'b0;
        satp_mode = SATP_SV39;
        satp_asid = 16'h0005;
        flush = 1'b0;
        sflush_vma_valid = 1'b0;
        miss_ready = 1'b0;
        pte_valid = 1'b0;
        pte = '0;
        pte_error = 1'b0;
        mmu_fifo_valid = 1'b0;
        vaddr = '0;
        store = 1'b0;
        paddr_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test("bypass");
        va_a = page_addr(VPN_A);
        current_priv = dmmu_pkg::PRV_M;
        translate(va_a, 1'b1, va_a, 1'b0, 1'b0, 1'b1);
        translate(64'h8000_0000_0000_1000, 1'b0, 64'h8000_0000_0000_1000, 1'b0, 1'b0, 1'b1);
        current_priv = dmmu_pkg::PRV_S;
        mprv = 1'b1;
        mpp = dmmu_pkg::PRV_M;
        translate(va_a, 1'b0, va_a, 1'b0, 1'b0, 1'b1);
        mprv = 1'b0;
        satp_mode = dmmu_pkg::SATP_BARE;
        translate(va_a, 1'b1, va_a, 1'b0, 1'b0, 1'b1);
        satp_mode = SATP_SV39;
        finish_test();

        start_test("miss, refill and hit");
        add_entry(VPN_A, 16'h0005, 3'd0, P_R | P_W, 1'b0);
        access_page(VPN_A, 0, 1'b0, 1'b0, 1'b1);
        access_page(VPN_A, 0, 1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("superpage response");
        add_entry(VPN_B, 16'h0005, 3'd1, P_R | P_W, 1'b0);
        add_entry(VPN_C, 16'h0005, 3'd2, P_R | P_W, 1'b0);
        access_page(VPN_B, 1, 1'b0, 1'b0, 1'b1);
        access_page(VPN_B, 1, 1'b0, 1'b0, 1'b1);
        access_page(VPN_C, 2, 1'b1, 1'b0, 1'b1);
        access_page(VPN_C, 2, 1'b0, 1'b0, 1'b1);
        finish_test();

        start_test("faults");
        add_entry(VPN_D, 16'h0005, 3'd0, P_R, 1'b0);
        add_entry(VPN_E, 16'h0005, 3'd0, P_X, 1'b0);
        add_entry(VPN_F, 16'h0005, 3'd0, P_R | P_W | P_U, 1'b0);
        add_entry(VPN_G, 16'h0005, 3'd0, P_R | P_W, 1'b0);
        add_entry(VPN_H, 16'h0005, 3'd0, P_R | P_W, 1'b1);
        access_page(VPN_D, 0, 1'b1, 1'b1, 1'b1);
        access_page(VPN_E, 0, 1'b0, 1'b1, 1'b1);
        mxr = 1'b1;
        access_page(VPN_E, 0, 1'b0, 1'b0, 1'b0);
        mxr = 1'b0;
        access_page(VPN_F, 0, 1'b0, 1'b1, 1'b1);
        sum = 1'b1;
        access_page(VPN_F, 0, 1'b1, 1'b0, 1'b0);
        sum = 1'b0;
        current_priv = dmmu_pkg::PRV_U;
        access_page(VPN_G, 0, 1'b0, 1'b1, 1'b1);
        current_priv = dmmu_pkg::PRV_S;
        access_page(VPN_H, 0, 1'b0, 1'b1, 1'b1);
        translate(64'h0000_0040_0000_1000, 1'b0, '0, 1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("invalidation and asid");
        access_page(VPN_A, 0, 1'b0, 1'b0, 1'b0);
        sflush_vma_valid = 1'b1;
        @(posedge clk);
        #1;
        sflush_vma_valid = 1'b0;
        access_page(VPN_A, 0, 1'b0, 1'b0, 1'b1);
        satp_asid = 16'h0006;
        access_page(VPN_A, 0, 1'b0, 1'b0, 1'b1);
        add_entry(VPN_J, 16'h0005, 3'd0, P_R | P_W | P_G, 1'b0);
        access_page(VPN_J, 0, 1'b0, 1'b0, 1'b1);
        access_page(VPN_J, 0, 1'b1, 1'b0, 1'b0);
        satp_asid = 16'h0005;
        finish_test();

        start_test("back-pressure and flush");
        add_entry(VPN_K, 16'h0005, 3'd0, P_R | P_W, 1'b0);
        va_a = page_addr(VPN_A);
        va_k = page_addr(VPN_K);
        held_pa = expected_paddr(ppn_for(VPN_A), 0, va_a);
        paddr_ready = 1'b0;
        translate(va_a, 1'b0, held_pa, 1'b0, 1'b0, 1'b1);
        mmu_fifo_valid = 1'b1;
        vaddr = page_addr(VPN_J);
        store = 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (!mmu_fifo_ready)
                else report_mismatch("mmu_fifo_ready", 64'(mmu_fifo_ready), 64'd0);
            assert (paddr == held_pa) else report_mismatch("paddr", paddr, held_pa);
        end
        // walk a new page, then flush it while the slot is still full
        @(posedge clk);
        #1;
        vaddr = va_k;
        waited = 0;
        while (!miss_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!miss_valid) begin
            $display("no walk request was raised for the page to be flushed");
            errors++;
        end
        flush = 1'b1;
        mmu_fifo_valid = 1'b0;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        assert (!paddr_valid) else report_mismatch("paddr_valid", 64'(paddr_valid), 64'd0);
        assert (!miss_valid) else report_mismatch("miss_valid", 64'(miss_valid), 64'd0);
        @(posedge clk);
        #1;
        paddr_ready = 1'b1;
        translate(va_k, 1'b0, expected_paddr(ppn_for(VPN_K), 0, va_k), 1'b0, 1'b1, 1'b1);
        finish_test();

        $display("tests %0d failed %0d errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dmmu testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module dmmu_tb -f sim.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdmmu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi
exit 1

//--- sim.f
source/dmmu_pkg.sv
source/dtlb_array.sv
source/miss_fsm.sv
source/translate_check.sv
source/paddr_stage.sv
source/dmmu_top.sv
bench/dmmu_chk.sv
bench/dmmu_tb.sv

//--- source/dmmu_pkg.sv
package dmmu_pkg;

    // **************************************************
    // widths
    // **************************************************
    typedef logic [63:0]  vaddr_t;
    typedef logic [63:0]  paddr_t;
    typedef logic [127:0] pte_t;
    typedef logic [26:0]  vpn_t;
    typedef logic [43:0]  ppn_t;
    typedef logic [15:0]  asid_t;
    typedef logic [1:0]   priv_t;
    typedef logic [2:0]   level_t;

    // privilege levels
    localparam priv_t PRV_U = 2'b00;
    localparam priv_t PRV_S = 2'b01;
    localparam priv_t PRV_M = 2'b11;

    // satp mode with translation off
    localparam logic [3:0] SATP_BARE = 4'h0;

    localparam int VA_BITS          = 39;
    localparam int PAGE_OFFSET_BITS = 12;

    // page size codes carried in the level field
    localparam level_t LVL_4K = 3'd0;
    localparam level_t LVL_2M = 3'd1;
    localparam level_t LVL_1G = 3'd2;

    // **************************************************
    // entry layout from the second-level TLB
    // **************************************************
    localparam int PTE_LEVEL_MSB = 2;
    localparam int PTE_LEVEL_LSB = 0;

    localparam int PTE_VPN_MSB = 57;
    localparam int PTE_VPN_LSB = 31;

    // permission and attribute bits
    localparam int PTE_R = 59;
    localparam int PTE_W = 60;
    localparam int PTE_X = 61;
    localparam int PTE_U = 62;
    localparam int PTE_G = 63;

    localparam int PTE_PPN_MSB = 111;
    localparam int PTE_PPN_LSB = 68;

    localparam int PTE_ASID_MSB = 127;
    localparam int PTE_ASID_LSB = 112;

endpackage

//--- source/dmmu_top.sv
module dmmu_top #(
    parameter int TLB_ENTRIES = 64
) (
    input  logic             clk,
    input  logic             rst_n,

    // csr state
    input  dmmu_pkg::priv_t  current_priv,
    input  logic             mprv,
    input  dmmu_pkg::priv_t  mpp,
    input  logic             mxr,
    input  logic             sum,
    input  logic [3:0]       satp_mode,
    input  dmmu_pkg::asid_t  satp_asid,

    input  logic             flush,
    input  logic             sflush_vma_valid,

    // second-level TLB
    output logic             miss_valid,
    input  logic             miss_ready,
    output dmmu_pkg::vaddr_t miss_vaddr,
    input  logic             pte_valid,
    input  dmmu_pkg::pte_t   pte,
    input  logic             pte_error,

    // request queue
    input  logic             mmu_fifo_valid,
    output logic             mmu_fifo_ready,
    input  dmmu_pkg::vaddr_t vaddr,
    input  logic             store,

    // data cache
    output logic             paddr_valid,
    input  logic             paddr_ready,
    output dmmu_pkg::paddr_t paddr,
    output logic             paddr_error
);

    logic             hit;
    dmmu_pkg::pte_t   hit_entry;
    logic             held_valid;
    dmmu_pkg::pte_t   held_entry;
    logic             held_error;
    logic             refill;
    dmmu_pkg::pte_t   refill_entry;
    logic             need_walk;
    logic             resolved;
    dmmu_pkg::paddr_t paddr_next;
    logic             error_next;
    logic             accept;

    // the walk always targets the queue head
    assign miss_vaddr = vaddr;

    dtlb_array #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk              (clk),
        .rst_n            (rst_n),
        .sflush_vma_valid (sflush_vma_valid),
        .lookup_vaddr     (vaddr),
        .satp_asid        (satp_asid),
        .refill           (refill),
        .refill_entry     (refill_entry),
        .hit              (hit),
        .hit_entry        (hit_entry)
    );

    miss_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .need_walk    (need_walk),
        .miss_ready   (miss_ready),
        .pte_valid    (pte_valid),
        .pte          (pte),
        .pte_error    (pte_error),
        .accept       (accept),
        .miss_valid   (miss_valid),
        .held_valid   (held_valid),
        .held_entry   (held_entry),
        .held_error   (held_error),
        .refill       (refill),
        .refill_entry (refill_entry)
    );

    translate_check u_check (
        .mmu_fifo_valid (mmu_fifo_valid),
        .vaddr          (vaddr),
        .store          (store),
        .current_priv   (current_priv),
        .mprv           (mprv),
        .mpp            (mpp),
        .mxr            (mxr),
        .sum            (sum),
        .satp_mode      (satp_mode),
        .hit            (hit),
        .hit_entry      (hit_entry),
        .held_valid     (held_valid),
        .held_entry     (held_entry),
        .held_error     (held_error),
        .resolved       (resolved),
        .need_walk      (need_walk),
        .paddr_next     (paddr_next),
        .error_next     (error_next)
    );

    paddr_stage u_out (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .mmu_fifo_valid (mmu_fifo_valid),
        .resolved       (resolved),
        .paddr_next     (paddr_next),
        .error_next     (error_next),
        .paddr_ready    (paddr_ready),
        .mmu_fifo_ready (mmu_fifo_ready),
        .accept         (accept),
        .paddr_valid    (paddr_valid),
        .paddr          (paddr),
        .paddr_error    (paddr_error)
    );

endmodule

//--- source/dtlb_array.sv
module dtlb_array #(
    parameter int TLB_ENTRIES = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sflush_vma_valid,
    input  dmmu_pkg::vaddr_t lookup_vaddr,
    input  dmmu_pkg::asid_t  satp_asid,
    input  logic             refill,
    input  dmmu_pkg::pte_t   refill_entry,
    output logic             hit,
    output dmmu_pkg::pte_t   hit_entry
);

    localparam int IDX_BITS = $clog2(TLB_ENTRIES);

    logic [IDX_BITS-1:0]    index;
    dmmu_pkg::vpn_t         va_vpn;
    dmmu_pkg::vpn_t         entry_vpn;
    dmmu_pkg::asid_t        entry_asid;
    logic                   asid_match;
    logic [TLB_ENTRIES-1:0] entry_valid;
    dmmu_pkg::pte_t         entries [TLB_ENTRIES];

    // **************************************************
    // lookup
    // **************************************************

    // index sits just above the page offset
    assign index  = lookup_vaddr[dmmu_pkg::PAGE_OFFSET_BITS +: IDX_BITS];
    assign va_vpn = lookup_vaddr[dmmu_pkg::VA_BITS-1:dmmu_pkg::PAGE_OFFSET_BITS];

    assign hit_entry  = entries[index];
    assign entry_vpn  = hit_entry[dmmu_pkg::PTE_VPN_MSB:dmmu_pkg::PTE_VPN_LSB];
    assign entry_asid = hit_entry[dmmu_pkg::PTE_ASID_MSB:dmmu_pkg::PTE_ASID_LSB];

    // global pages ignore the asid
    assign asid_match = (entry_asid == satp_asid) | hit_entry[dmmu_pkg::PTE_G];

    assign hit = entry_valid[index] & (entry_vpn == va_vpn) & asid_match;

    // **************************************************
    // refill and invalidation
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (sflush_vma_valid) begin
            entry_valid <= '0;
        end else if (refill) begin
            entry_valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            entries[index] <= refill_entry;
        end
    end

endmodule

//--- source/miss_fsm.sv
module miss_fsm (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           need_walk,
    input  logic           miss_ready,
    input  logic           pte_valid,
    input  dmmu_pkg::pte_t pte,
    input  logic           pte_error,
    input  logic           accept,
    output logic           miss_valid,
    output logic           held_valid,
    output dmmu_pkg::pte_t held_entry,
    output logic           held_error,
    output logic           refill,
    output dmmu_pkg::pte_t refill_entry
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT,
        HELD
    } miss_state_t;

    miss_state_t      state;
    dmmu_pkg::level_t pte_level;
    logic             resp_taken;

    assign pte_level  = pte[dmmu_pkg::PTE_LEVEL_MSB:dmmu_pkg::PTE_LEVEL_LSB];
    assign resp_taken = (state == WAIT) & pte_valid;

    // **************************************************
    // state machine
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (need_walk) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (miss_ready) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (pte_valid) begin
                        state <= HELD;
                    end
                end
                HELD: begin
                    // released by the same acceptance that consumes it
                    if (accept) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // returned entry and its error flag
    always_ff @(posedge clk) begin
        if (resp_taken) begin
            held_entry <= pte;
            held_error <= pte_error;
        end
    end

    assign miss_valid = (state == REQUEST);
    assign held_valid = (state == HELD);

    // only 4K pages go into the array
    assign refill       = resp_taken & ~flush & ~pte_error & (pte_level == dmmu_pkg::LVL_4K);
    assign refill_entry = pte;

endmodule

//--- source/paddr_stage.sv
module paddr_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             mmu_fifo_valid,
    input  logic             resolved,
    input  dmmu_pkg::paddr_t paddr_next,
    input  logic             error_next,
    input  logic             paddr_ready,
    output logic             mmu_fifo_ready,
    output logic             accept,
    output logic             paddr_valid,
    output dmmu_pkg::paddr_t paddr,
    output logic             paddr_error
);

    logic slot_free;

    // empty slot or one draining this cycle
    assign slot_free      = ~paddr_valid | paddr_ready;
    assign mmu_fifo_ready = mmu_fifo_valid & resolved & slot_free;
    assign accept         = mmu_fifo_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddr_valid <= 1'b0;
        end else if (flush) begin
            paddr_valid <= 1'b0;
        end else if (slot_free) begin
            paddr_valid <= accept;
        end
    end

    // holds while the cache stalls
    always_ff @(posedge clk) begin
        if (accept) begin
            paddr       <= paddr_next;
            paddr_error <= error_next;
        end
    end

endmodule

//--- source/translate_check.sv
module translate_check (
    input  logic             mmu_fifo_valid,
    input  dmmu_pkg::vaddr_t vaddr,
    input  logic             store,
    input  dmmu_pkg::priv_t  current_priv,
    input  logic             mprv,
    input  dmmu_pkg::priv_t  mpp,
    input  logic             mxr,
    input  logic             sum,
    input  logic [3:0]       satp_mode,
    input  logic             hit,
    input  dmmu_pkg::pte_t   hit_entry,
    input  logic             held_valid,
    input  dmmu_pkg::pte_t   held_entry,
    input  logic             held_error,
    output logic             resolved,
    output logic             need_walk,
    output dmmu_pkg::paddr_t paddr_next,
    output logic             error_next
);

    dmmu_pkg::priv_t  eff_priv;
    logic             bypass;
    logic             canonical;
    dmmu_pkg::pte_t   entry;
    dmmu_pkg::level_t level;
    dmmu_pkg::ppn_t   ppn;
    dmmu_pkg::paddr_t paddr_xlate;
    logic             fault_store;
    logic             fault_load;
    logic             fault_user;
    logic             fault_sup;

    // **************************************************
    // bypass and resolution
    // **************************************************
    assign eff_priv = mprv ? mpp : current_priv;
    assign bypass   = (eff_priv == dmmu_pkg::PRV_M) | (satp_mode == dmmu_pkg::SATP_BARE);

    // upper bits must all copy bit 38
    assign canonical = (&vaddr[63:dmmu_pkg::VA_BITS-1]) | ~(|vaddr[63:dmmu_pkg::VA_BITS-1]);

    assign resolved  = bypass | ~canonical | hit | held_valid;
    assign need_walk = mmu_fifo_valid & ~resolved;

    // **************************************************
    // address composition
    // **************************************************

    // a held entry wins over the array
    assign entry = held_valid ? held_entry : hit_entry;
    assign level = entry[dmmu_pkg::PTE_LEVEL_MSB:dmmu_pkg::PTE_LEVEL_LSB];
    assign ppn   = entry[dmmu_pkg::PTE_PPN_MSB:dmmu_pkg::PTE_PPN_LSB];

    always_comb begin
        case (level)
            dmmu_pkg::LVL_4K: paddr_xlate = {8'h00, ppn, vaddr[11:0]};
            dmmu_pkg::LVL_2M: paddr_xlate = {8'h00, ppn[43:9], vaddr[20:0]};
            dmmu_pkg::LVL_1G: paddr_xlate = {8'h00, ppn[43:18], vaddr[29:0]};
            default:          paddr_xlate = '0;
        endcase
    end

    assign paddr_next = bypass ? vaddr : paddr_xlate;

    // **************************************************
    // permission check
    // **************************************************
    assign fault_store = store & ~entry[dmmu_pkg::PTE_W];

    // executable pages are readable under mxr
    assign fault_load = ~store & ~entry[dmmu_pkg::PTE_R] & ~(entry[dmmu_pkg::PTE_X] & mxr);

    assign fault_user = (eff_priv == dmmu_pkg::PRV_U) & ~entry[dmmu_pkg::PTE_U];
    assign fault_sup  = (eff_priv == dmmu_pkg::PRV_S) & entry[dmmu_pkg::PTE_U] & ~sum;

    assign error_next = ~bypass & (~canonical
                                   | fault_store
                                   | fault_load
                                   | fault_user
                                   | fault_sup
                                   | (held_valid & held_error));

endmodule
